// ==== list.f ====
gpio_pkg.sv
gpio_regs.sv
gpio_in_sync.sv
gpio_pad_model.sv
gpio_top.sv
tb_gpio.sv

// ==== tb_gpio.sv ====
/* Testbench for the GPIO subsystem top level.
   Drives the Wishbone port and the host pins, and checks the registers, pads
   and interrupts with concurrent and immediate assertions. */
`timescale 1ns/10ps

module tb_gpio;
  import gpio_pkg::*;

  localparam int half_period = 50;                     // 100 ns clock
  localparam int drive_dly   = 1;                      // Inputs change just after the edge
  localparam int ack_timeout = 16;
  localparam int irq_timeout = 16;

  logic              eff_clk;
  logic              rst_ni;
  wb_req_t           wb_req;
  wb_rsp_t           wb_rsp;
  logic [n_gpio-1:0] host_drv;
  logic [n_gpio-1:0] host_en;
  logic [n_gpio-1:0] pads;
  logic              irq;

  logic              state_known;                      // Set while last_state matches the DUT
  logic [n_gpio-1:0] last_state;                       // Last intr_state value read on the bus

  gpio_top DUT (
    .eff_clk  (eff_clk),
    .rst_ni   (rst_ni),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .host_drv (host_drv),
    .host_en  (host_en),
    .pads     (pads),
    .irq      (irq)
  );

  initial begin
    eff_clk = 1'b0;
    forever #(half_period) eff_clk = ~eff_clk;
  end

  // --------------------
  // Reporting
  // --------------------

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else stop_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
  endtask

  // --------------------
  // Bus protocol checks
  // --------------------

  ack_one_cycle: assert property (@(posedge eff_clk) disable iff (!rst_ni)
    wb_rsp.ack |=> !wb_rsp.ack)
    else stop_run("Wishbone ack stayed high for more than one cycle");

  ack_after_request: assert property (@(posedge eff_clk) disable iff (!rst_ni)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else stop_run("Wishbone ack came without a cyc and stb request");

  // Only armed while no edge or clear can change the state
  irq_follows_state: assert property (@(posedge eff_clk) disable iff (!rst_ni)
    state_known |-> (irq == (|last_state)))
    else stop_run($sformatf("CHECK FAILED irq_vs_state expected %b actual %b",
                            |$sampled(last_state), $sampled(irq)));

  // --------------------
  // Stimulus tasks
  // --------------------

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge eff_clk);
      #(drive_dly);
    end
  endtask

  task automatic wait_ack();
    int cycles;
    cycles = 0;
    do begin
      @(posedge eff_clk);
      #(drive_dly);
      cycles++;
    end while (!wb_rsp.ack && cycles < ack_timeout);
    if (!wb_rsp.ack) stop_run("Wishbone ack did not arrive within the timeout");
  endtask

  task automatic wb_write(input logic [wb_aw-1:0] adr, input logic [31:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    wait_ack();
    wait_cycles(1);                                    // Master sees ack on the next edge
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic wb_read(input logic [wb_aw-1:0] adr, output logic [31:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wait_ack();
    dat = wb_rsp.dat;
    wait_cycles(1);
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic read_check(input string name, input logic [wb_aw-1:0] adr,
                            input logic [31:0] exp);
    logic [31:0] rd;
    wb_read(adr, rd);
    check_value(name, exp, rd);
  endtask

  // Call only while the pins are quiet, it arms the irq check
  task automatic sample_intr_state(input string name, input logic [31:0] exp);
    logic [31:0] rd;
    wb_read(reg_intr_state, rd);
    check_value(name, exp, rd);
    last_state  = rd;
    state_known = 1'b1;
  endtask

  task automatic wait_irq_high();
    int cycles;
    cycles = 0;
    while (!irq && cycles < irq_timeout) begin
      @(posedge eff_clk);
      #(drive_dly);
      cycles++;
    end
    if (!irq) stop_run("irq did not rise after the host toggled enabled pins");
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    logic [31:0]      vals [6];
    logic [wb_aw-1:0] rw_regs [6];
    logic [31:0]      mask, val, known, hm, hd, pe, ps, exp;
    logic [31:0]      re, fe, p0, p1, chg, clr, rd;

    void'($urandom(32'hdad382cb));
    rst_ni      = 1'b0;
    wb_req      = '0;
    host_drv    = '0;
    host_en     = '0;
    state_known = 1'b0;
    last_state  = '0;
    repeat (4) @(posedge eff_clk);
    #(drive_dly);
    rst_ni = 1'b1;

    // Reset values
    for (int a = 0; a < 8; a++) begin
      read_check($sformatf("reset_reg%0d", a), a[wb_aw-1:0], 32'h0);
    end
    check_value("reset_pads", 32'h0, pads);
    check_value("reset_irq", 32'h0, {31'h0, irq});

    // Register readback with random data
    rw_regs[0] = reg_data_out;
    rw_regs[1] = reg_dir;
    rw_regs[2] = reg_pull_en;
    rw_regs[3] = reg_pull_sel;
    rw_regs[4] = reg_intr_rise_en;
    rw_regs[5] = reg_intr_fall_en;
    for (int i = 0; i < 6; i++) begin
      vals[i] = $urandom();
      wb_write(rw_regs[i], vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      read_check($sformatf("readback_reg%0d", rw_regs[i]), rw_regs[i], vals[i]);
    end
    wb_write(reg_intr_rise_en, 32'h0);
    wb_write(reg_intr_fall_en, 32'h0);

    // Device drive wins over the host on output bits
    mask = $urandom();
    val  = $urandom();
    wb_write(reg_dir, mask);
    wb_write(reg_data_out, val);
    check_value("device_drive", val & mask, pads & mask);
    host_en  = mask;
    host_drv = ~val;
    wait_cycles(3);
    check_value("device_over_host", val & mask, pads & mask);
    wb_read(reg_data_in, rd);
    check_value("device_data_in", val & mask, rd & mask);

    // Host drive, pulls and kept values with all outputs off
    wb_write(reg_dir, 32'h0);
    known    = $urandom();
    host_en  = '1;
    host_drv = known;
    wait_cycles(1);
    check_value("host_preset", known, pads);
    pe = $urandom();
    ps = $urandom();
    wb_write(reg_pull_sel, ps);
    wb_write(reg_pull_en, pe);
    hm       = $urandom();
    hd       = $urandom();
    host_en  = hm;
    host_drv = hd;
    exp = (hm & hd) | (~hm & pe & ps) | (~hm & ~pe & known);
    wait_cycles(1);
    check_value("pad_resolve", exp, pads);
    wait_cycles(2);
    read_check("host_data_in", reg_data_in, exp);

    // Edge interrupts
    re = $urandom() | 32'h1;                           // Bit 0 is sure to interrupt
    fe = $urandom() | 32'h1;
    wb_write(reg_intr_rise_en, re);
    wb_write(reg_intr_fall_en, fe);
    p0       = $urandom();
    host_en  = '1;
    host_drv = p0;
    wait_cycles(6);
    wb_write(reg_intr_state, 32'hffff_ffff);
    sample_intr_state("intr_cleared", 32'h0);
    check_value("irq_low", 32'h0, {31'h0, irq});
    wait_cycles(1);

    state_known = 1'b0;
    chg      = $urandom() | 32'h1;
    p1       = p0 ^ chg;
    host_drv = p1;
    exp = (chg & p1 & re) | (chg & p0 & fe);
    wait_irq_high();
    wait_cycles(2);
    sample_intr_state("intr_edges", exp);
    wait_cycles(1);

    state_known = 1'b0;
    clr = exp & $urandom();
    wb_write(reg_intr_state, clr);
    sample_intr_state("intr_partial_clear", exp & ~clr);
    wait_cycles(1);
    state_known = 1'b0;
    wb_write(reg_intr_state, exp & ~clr);
    sample_intr_state("intr_full_clear", 32'h0);
    check_value("irq_dropped", 32'h0, {31'h0, irq});
    wait_cycles(2);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== gpio_top.sv ====
/* Top level of the GPIO subsystem.
   Ties the register block, the pad model and the input synchronizer to the
   Wishbone port, the host drive ports and the pad outputs. */
`timescale 1ns/10ps

module gpio_top (
  input  logic                        eff_clk,
  input  logic                        rst_ni,
  input  gpio_pkg::wb_req_t           wb_req,
  output gpio_pkg::wb_rsp_t           wb_rsp,
  input  logic [gpio_pkg::n_gpio-1:0] host_drv,
  input  logic [gpio_pkg::n_gpio-1:0] host_en,
  output logic [gpio_pkg::n_gpio-1:0] pads,
  output logic                        irq
);
  import gpio_pkg::*;

  // --------------------
  // Internal wires
  // --------------------

  pad_ctrl_t         pad_ctrl;                         // Device drive onto the pads
  logic [n_gpio-1:0] data_in;                          // Synchronized pad values
  logic [n_gpio-1:0] rise;
  logic [n_gpio-1:0] fall;

  // --------------------
  // Blocks
  // --------------------

  gpio_regs u_regs (
    .eff_clk  (eff_clk),
    .rst_ni   (rst_ni),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .pad_ctrl (pad_ctrl),
    .data_in  (data_in),
    .rise     (rise),
    .fall     (fall),
    .irq      (irq)
  );

  gpio_pad_model u_pad_model (
    .eff_clk  (eff_clk),
    .rst_ni   (rst_ni),
    .pad_ctrl (pad_ctrl),
    .host_drv (host_drv),
    .host_en  (host_en),
    .pads     (pads)
  );

  // Pads loop back into the device through the synchronizer
  gpio_in_sync u_in_sync (
    .eff_clk (eff_clk),
    .rst_ni  (rst_ni),
    .pads    (pads),
    .data_in (data_in),
    .rise    (rise),
    .fall    (fall)
  );

endmodule

// ==== gpio_pad_model.sv ====
/* Pad-side model of the GPIO pins, standing between the device and a host.
   Every clock each pad takes its value from the highest priority source. */
`timescale 1ns/10ps

module gpio_pad_model (
  input  logic                        eff_clk,
  input  logic                        rst_ni,
  input  gpio_pkg::pad_ctrl_t         pad_ctrl,
  input  logic [gpio_pkg::n_gpio-1:0] host_drv,
  input  logic [gpio_pkg::n_gpio-1:0] host_en,
  output logic [gpio_pkg::n_gpio-1:0] pads
);
  import gpio_pkg::*;

  logic [n_gpio-1:0] pads_d;
  logic [n_gpio-1:0] pads_q;

  // --------------------
  // Source resolution
  // --------------------

  // Device first, then host, then pull, else the pin floats at its last value
  always_comb begin
    for (int i = 0; i < n_gpio; i++) begin
      if (pad_ctrl.oe[i]) begin
        pads_d[i] = pad_ctrl.out[i];                   // Device owns the pin
      end else if (host_en[i]) begin
        pads_d[i] = host_drv[i];                       // Host drives an input pin
      end else if (pad_ctrl.pull_en[i]) begin
        pads_d[i] = pad_ctrl.pull_sel[i];              // Weak pull wins on an idle pin
      end else begin
        pads_d[i] = pads_q[i];                         // Nobody drives, charge is kept
      end
    end
  end

  // --------------------
  // Pad register
  // --------------------

  // Any change on the inputs shows on the pads one cycle later
  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pads_q <= '0;
    end else begin
      pads_q <= pads_d;
    end
  end

  assign pads = pads_q;

endmodule

// ==== gpio_in_sync.sv ====
/* Two-flop synchronizer for the pad values with edge detection.
   data_in lags the pads by two cycles and the edge pulses line up with it. */
`timescale 1ns/10ps

module gpio_in_sync (
  input  logic                        eff_clk,
  input  logic                        rst_ni,
  input  logic [gpio_pkg::n_gpio-1:0] pads,
  output logic [gpio_pkg::n_gpio-1:0] data_in,
  output logic [gpio_pkg::n_gpio-1:0] rise,
  output logic [gpio_pkg::n_gpio-1:0] fall
);
  import gpio_pkg::*;

  // --------------------
  // Synchronizer stages
  // --------------------

  logic [n_gpio-1:0] sync1_q;                          // First stage, may go metastable
  logic [n_gpio-1:0] sync2_q;                          // Settled copy of the pads
  logic [n_gpio-1:0] prev_q;                           // Value of sync2_q one cycle ago

  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= pads;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  // --------------------
  // Edge detection
  // --------------------

  // Pulses last one cycle, during the first cycle of the new data_in value
  assign rise = sync2_q & ~prev_q;
  assign fall = ~sync2_q & prev_q;

  assign data_in = sync2_q;

endmodule

// ==== gpio_regs.sv ====
/* GPIO register block on a Wishbone classic slave port.
   Drives the pad control, reads back synchronized pins and keeps the
   edge interrupt state that feeds the level irq output. */
`timescale 1ns/10ps

module gpio_regs (
  input  logic                        eff_clk,
  input  logic                        rst_ni,
  input  gpio_pkg::wb_req_t           wb_req,
  output gpio_pkg::wb_rsp_t           wb_rsp,
  output gpio_pkg::pad_ctrl_t         pad_ctrl,
  input  logic [gpio_pkg::n_gpio-1:0] data_in,
  input  logic [gpio_pkg::n_gpio-1:0] rise,
  input  logic [gpio_pkg::n_gpio-1:0] fall,
  output logic                        irq
);
  import gpio_pkg::*;

  // --------------------
  // Bus handshake
  // --------------------

  logic              ack_q;
  logic              access;
  logic              wr_en;
  logic [n_gpio-1:0] wr_data;

  assign access  = wb_req.cyc & wb_req.stb & ~ack_q;  // New transfer seen on this edge
  assign wr_en   = access & wb_req.we;
  assign wr_data = wb_req.dat[n_gpio-1:0];

  // Ack rises on the first edge of a transfer and drops on the next one
  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // --------------------
  // Control registers
  // --------------------

  pad_ctrl_t         pad_ctrl_q;
  logic [n_gpio-1:0] intr_rise_en_q;
  logic [n_gpio-1:0] intr_fall_en_q;

  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pad_ctrl_q     <= '0;
      intr_rise_en_q <= '0;
      intr_fall_en_q <= '0;
    end else if (wr_en) begin
      case (wb_req.adr)
        reg_data_out:     pad_ctrl_q.out      <= wr_data;
        reg_dir:          pad_ctrl_q.oe       <= wr_data;
        reg_pull_en:      pad_ctrl_q.pull_en  <= wr_data;
        reg_pull_sel:     pad_ctrl_q.pull_sel <= wr_data;
        reg_intr_rise_en: intr_rise_en_q      <= wr_data;
        reg_intr_fall_en: intr_fall_en_q      <= wr_data;
        default: ;                                     // data_in is read only, intr_state below
      endcase
    end
  end

  assign pad_ctrl = pad_ctrl_q;

  // --------------------
  // Interrupt state
  // --------------------

  logic [n_gpio-1:0] intr_state_q;
  logic [n_gpio-1:0] intr_set;
  logic [n_gpio-1:0] intr_clr;

  assign intr_set = (rise & intr_rise_en_q) | (fall & intr_fall_en_q);

  always_comb begin
    intr_clr = '0;
    if (wr_en && (wb_req.adr == reg_intr_state)) begin
      intr_clr = wr_data;                              // Ones clear, zeros leave bits alone
    end
  end

  // A new edge in the same cycle as its clear keeps the bit set
  always_ff @(posedge eff_clk or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_state_q <= '0;
    end else begin
      intr_state_q <= (intr_state_q & ~intr_clr) | intr_set;
    end
  end

  assign irq = |intr_state_q;                          // Level interrupt, any pending bit

  // --------------------
  // Read path
  // --------------------

  logic [n_gpio-1:0] rd_bits;
  logic [wb_dw-1:0]  rdata_d;
  logic [wb_dw-1:0]  rdata_q;

  always_comb begin
    rd_bits = '0;
    case (wb_req.adr)
      reg_data_out:     rd_bits = pad_ctrl_q.out;
      reg_dir:          rd_bits = pad_ctrl_q.oe;
      reg_pull_en:      rd_bits = pad_ctrl_q.pull_en;
      reg_pull_sel:     rd_bits = pad_ctrl_q.pull_sel;
      reg_data_in:      rd_bits = data_in;
      reg_intr_state:   rd_bits = intr_state_q;
      reg_intr_rise_en: rd_bits = intr_rise_en_q;
      reg_intr_fall_en: rd_bits = intr_fall_en_q;
      default:          rd_bits = '0;
    endcase
  end

  // Bits above the pin count read as zero
  always_comb begin
    rdata_d              = '0;
    rdata_d[n_gpio-1:0]  = rd_bits;
  end

  // Captured on the same edge that raises ack, so it is stable during ack
  always_ff @(posedge eff_clk) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdata_q;

endmodule

// ==== gpio_pkg.sv ====
/* Shared definitions for the GPIO subsystem.
   Holds the pin count, the register map and the structs that carry the
   Wishbone bus and the pad control between the blocks. */
package gpio_pkg;

  // --------------------
  // Sizes
  // --------------------

  localparam int n_gpio = 32;                        // Pins handled by the subsystem
  localparam int wb_aw  = 3;                         // Word address width of the register map
  localparam int wb_dw  = 32;                        // Wishbone data width

  // --------------------
  // Register map
  // --------------------

  // Word addresses on the Wishbone bus
  localparam logic [wb_aw-1:0] reg_data_out     = 'd0;  // Output values
  localparam logic [wb_aw-1:0] reg_dir          = 'd1;  // Output enables
  localparam logic [wb_aw-1:0] reg_pull_en      = 'd2;  // Pull enables
  localparam logic [wb_aw-1:0] reg_pull_sel     = 'd3;  // Pull direction, one is pull-up
  localparam logic [wb_aw-1:0] reg_data_in      = 'd4;  // Synchronized pin values, read only
  localparam logic [wb_aw-1:0] reg_intr_state   = 'd5;  // Pending edges, write one to clear
  localparam logic [wb_aw-1:0] reg_intr_rise_en = 'd6;  // Rising edge interrupt enables
  localparam logic [wb_aw-1:0] reg_intr_fall_en = 'd7;  // Falling edge interrupt enables

  // --------------------
  // Bus structs
  // --------------------

  // Master to slave, held stable by the master until ack
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [wb_aw-1:0] adr;
    logic [wb_dw-1:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic             ack;                         // High for exactly one cycle per transfer
    logic [wb_dw-1:0] dat;                         // Read data, valid while ack is high
  } wb_rsp_t;

  // --------------------
  // Pad control
  // --------------------

  // What the device asks of each pin
  typedef struct packed {
    logic [n_gpio-1:0] out;                        // Values driven where oe is set
    logic [n_gpio-1:0] oe;                         // Device output enables
    logic [n_gpio-1:0] pull_en;                    // Pull enables for undriven pins
    logic [n_gpio-1:0] pull_sel;                   // One pulls up, zero pulls down
  } pad_ctrl_t;

endpackage
